// File: dut.sv
//**********************************************************
// Memory subsystem top level.
// Connects the Wishbone command master, the SRAM slave
// and the pin sequencer to the request port and pins.
//**********************************************************

`timescale 1ns/10ps

module dut (
    input  logic                           clk,
    input  logic                           i_rst,

    // request port standing in for the processor core.
    input  logic                           i_req,
    input  logic                           i_req_we,
    input  procyon_system_pkg::wb_sel_t    i_req_sel,
    input  procyon_system_pkg::wb_addr_t   i_req_addr,
    input  procyon_system_pkg::wb_data_t   i_req_wdata,
    output logic                           o_busy,
    output logic                           o_done,
    output procyon_system_pkg::wb_data_t   o_rd_data,

    // SRAM pins, the data bus split into its two directions.
    output procyon_system_pkg::sram_addr_t o_sram_addr,
    input  procyon_system_pkg::sram_data_t i_sram_dq,
    output procyon_system_pkg::sram_data_t o_sram_dq,
    output logic                           o_sram_ce_n,
    output logic                           o_sram_oe_n,
    output logic                           o_sram_we_n,
    output logic                           o_sram_ub_n,
    output logic                           o_sram_lb_n
);

    wb_if       wb_bus ();
    sram_req_if sram_req ();

    wb_cmd_master wb_cmd_master_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_req(i_req),
        .i_req_we(i_req_we),
        .i_req_sel(i_req_sel),
        .i_req_addr(i_req_addr),
        .i_req_wdata(i_req_wdata),
        .o_busy(o_busy),
        .o_done(o_done),
        .o_rd_data(o_rd_data),
        .wb(wb_bus.master)
    );

    sram_top sram_top_inst (
        .clk(clk),
        .i_rst(i_rst),
        .wb(wb_bus.slave),
        .phy(sram_req.master)
    );

    sram_phy sram_phy_inst (
        .clk(clk),
        .i_rst(i_rst),
        .phy(sram_req.slave),
        .o_sram_addr(o_sram_addr),
        .i_sram_dq(i_sram_dq),
        .o_sram_dq(o_sram_dq),
        .o_sram_ce_n(o_sram_ce_n),
        .o_sram_oe_n(o_sram_oe_n),
        .o_sram_we_n(o_sram_we_n),
        .o_sram_ub_n(o_sram_ub_n),
        .o_sram_lb_n(o_sram_lb_n)
    );

endmodule

// File: filelist.f
procyon_system_pkg.sv
wb_if.sv
sram_req_if.sv
wb_cmd_master.sv
sram_top.sv
sram_phy.sv
dut.sv
tb_sram_model.sv
tb_dut.sv

// File: procyon_system_pkg.sv
//**********************************************************
// Shared definitions for the memory subsystem.
// Bus and SRAM widths, the SRAM window, access timing,
// and the common types and enums.
//**********************************************************

package procyon_system_pkg;

    // Wishbone bus geometry.
    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = 4;

    // external asynchronous SRAM geometry, one half-word per address.
    localparam int SRAM_DATA_WIDTH = 16;
    localparam int SRAM_ADDR_WIDTH = 18;

    // cycles that oe_n or we_n is held low for one half-word.
    localparam int SRAM_STROBE_CYCLES = 2;
    localparam int STROBE_CNT_WIDTH   = $clog2(SRAM_STROBE_CYCLES + 1);

    typedef logic [WB_DATA_WIDTH-1:0]   wb_data_t;
    typedef logic [WB_ADDR_WIDTH-1:0]   wb_addr_t;
    typedef logic [WB_SEL_WIDTH-1:0]    wb_sel_t;
    typedef logic [SRAM_DATA_WIDTH-1:0] sram_data_t;
    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;

    // the window starts at the base and covers the whole SRAM in bytes (512 KiB).
    localparam wb_addr_t SRAM_BASE_ADDR  = 32'h0000_0000;
    localparam wb_addr_t SRAM_SIZE_BYTES =
        wb_addr_t'((2 ** SRAM_ADDR_WIDTH) * (SRAM_DATA_WIDTH / 8));

    typedef enum logic {
        SRAM_READ  = 1'b0,
        SRAM_WRITE = 1'b1
    } sram_op_t;

    typedef enum logic [1:0] {
        PHY_IDLE   = 2'b00,
        PHY_SETUP  = 2'b01,
        PHY_STROBE = 2'b10
    } phy_state_t;

endpackage

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status gives the result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_dut -o tb_dut
./obj_dir/tb_dut

// File: sram_phy.sv
//**********************************************************
// SRAM pin sequencer.
// Runs one half-word access on the asynchronous SRAM as a
// setup cycle followed by the oe_n or we_n strobe.
//**********************************************************

`timescale 1ns/10ps

module sram_phy (
    input  logic                           clk,
    input  logic                           i_rst,
    sram_req_if.slave                      phy,
    output procyon_system_pkg::sram_addr_t o_sram_addr,
    input  procyon_system_pkg::sram_data_t i_sram_dq,
    output procyon_system_pkg::sram_data_t o_sram_dq,
    output logic                           o_sram_ce_n,
    output logic                           o_sram_oe_n,
    output logic                           o_sram_we_n,
    output logic                           o_sram_ub_n,
    output logic                           o_sram_lb_n
);

    import procyon_system_pkg::*;

    phy_state_t                  state;
    logic [STROBE_CNT_WIDTH-1:0] strobe_cnt;
    logic                        strobe_last;
    logic                        active;
    sram_op_t                    op_q;
    sram_addr_t                  addr_q;
    sram_data_t                  wdata_q;
    logic                        ub_q;
    logic                        lb_q;

    assign strobe_last = (strobe_cnt == STROBE_CNT_WIDTH'(SRAM_STROBE_CYCLES - 1));
    assign active      = (state != PHY_IDLE);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state      <= PHY_IDLE;
            strobe_cnt <= '0;
        end else begin
            case (state)
                PHY_IDLE: begin
                    if (phy.req) begin
                        state <= PHY_SETUP;
                    end
                end
                PHY_SETUP: begin
                    strobe_cnt <= '0;
                    state      <= PHY_STROBE;
                end
                PHY_STROBE: begin
                    if (strobe_last) begin
                        state <= PHY_IDLE;
                    end else begin
                        strobe_cnt <= strobe_cnt + 1'b1;
                    end
                end
                default: state <= PHY_IDLE;
            endcase
        end
    end

    // address, data and lanes stay put for the whole access.
    always_ff @(posedge clk) begin
        if (state == PHY_IDLE && phy.req) begin
            op_q    <= phy.op;
            addr_q  <= phy.addr;
            wdata_q <= phy.wdata;
            ub_q    <= phy.ub;
            lb_q    <= phy.lb;
        end
    end

    assign o_sram_addr = addr_q;
    assign o_sram_ce_n = !active;
    assign o_sram_oe_n = !(state == PHY_STROBE && op_q == SRAM_READ);
    assign o_sram_we_n = !(state == PHY_STROBE && op_q == SRAM_WRITE);
    assign o_sram_ub_n = !(active && ub_q);
    assign o_sram_lb_n = !(active && lb_q);

    // only meaningful while we_n is low, which also marks the driving direction.
    assign o_sram_dq = wdata_q;

    // the slave samples the pins on the done edge, the last strobe cycle.
    assign phy.rdata = i_sram_dq;
    assign phy.done  = (state == PHY_STROBE) && strobe_last;

    assert property (@(posedge clk) disable iff (i_rst)
        !(!o_sram_oe_n && !o_sram_we_n));
    assert property (@(posedge clk) disable iff (i_rst)
        (!o_sram_oe_n || !o_sram_we_n) |-> !o_sram_ce_n);

endmodule

// File: sram_req_if.sv
//**********************************************************
// Half-word request channel from the Wishbone SRAM slave
// to the SRAM pin sequencer.
//**********************************************************

`timescale 1ns/10ps

interface sram_req_if;

    import procyon_system_pkg::*;

    logic       req;
    sram_op_t   op;
    sram_addr_t addr;
    sram_data_t wdata;
    logic       ub;
    logic       lb;
    sram_data_t rdata;
    logic       done;

    modport master (
        output req, op, addr, wdata, ub, lb,
        input  rdata, done
    );

    modport slave (
        input  req, op, addr, wdata, ub, lb,
        output rdata, done
    );

endinterface

// File: sram_top.sv
//**********************************************************
// Wishbone slave for a 16-bit asynchronous SRAM.
// Decodes the window, splits each word into half-word
// accesses and assembles the read data.
//**********************************************************

`timescale 1ns/10ps

module sram_top (
    input  logic       clk,
    input  logic       i_rst,
    wb_if.slave        wb,
    sram_req_if.master phy
);

    import procyon_system_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_LOWER = 2'b01,
        ST_UPPER = 2'b10,
        ST_ACK   = 2'b11
    } top_state_t;

    top_state_t                 state;
    logic                       req_q;
    wb_data_t                   rdata_q;
    wb_addr_t                   wb_offset;
    logic                       in_window;
    logic [SRAM_ADDR_WIDTH-2:0] word_idx;
    logic                       lower_sel;
    logic                       upper_sel;
    logic                       cur_upper;

    // the subtraction wraps below the base, so one compare covers both ends.
    assign wb_offset = wb.addr - SRAM_BASE_ADDR;
    assign in_window = (wb_offset < SRAM_SIZE_BYTES);
    assign word_idx  = wb_offset[SRAM_ADDR_WIDTH:2];
    assign lower_sel = |wb.sel[1:0];
    assign upper_sel = |wb.sel[3:2];
    assign cur_upper = (state == ST_UPPER);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
            req_q <= 1'b0;
        end else begin
            req_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wb.cyc && wb.stb) begin
                        if (!in_window || !(lower_sel || upper_sel)) begin
                            state <= ST_ACK;
                        end else if (lower_sel) begin
                            state <= ST_LOWER;
                            req_q <= 1'b1;
                        end else begin
                            state <= ST_UPPER;
                            req_q <= 1'b1;
                        end
                    end
                end
                ST_LOWER: begin
                    if (phy.done) begin
                        if (upper_sel) begin
                            state <= ST_UPPER;
                            req_q <= 1'b1;
                        end else begin
                            state <= ST_ACK;
                        end
                    end
                end
                ST_UPPER: begin
                    if (phy.done) begin
                        state <= ST_ACK;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // halves that are never read stay zero.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            rdata_q <= '0;
        end else if (phy.done && !wb.we) begin
            if (cur_upper) begin
                rdata_q[SRAM_DATA_WIDTH +: SRAM_DATA_WIDTH] <= phy.rdata;
            end else begin
                rdata_q[0 +: SRAM_DATA_WIDTH] <= phy.rdata;
            end
        end
    end

    // the request fields follow the current half; the bus holds them stable.
    assign phy.req   = req_q;
    assign phy.op    = wb.we ? SRAM_WRITE : SRAM_READ;
    assign phy.addr  = {word_idx, cur_upper};
    assign phy.wdata = cur_upper ? wb.dat_m2s[SRAM_DATA_WIDTH +: SRAM_DATA_WIDTH]
                                 : wb.dat_m2s[0 +: SRAM_DATA_WIDTH];
    assign phy.ub    = cur_upper ? wb.sel[3] : wb.sel[1];
    assign phy.lb    = cur_upper ? wb.sel[2] : wb.sel[0];

    assign wb.ack     = (state == ST_ACK);
    assign wb.dat_s2m = rdata_q;

    assert property (@(posedge clk) disable iff (i_rst) wb.ack |-> wb.stb);
    assert property (@(posedge clk) disable iff (i_rst)
        phy.req |=> (!phy.req until phy.done));

endmodule

// File: tb_dut.sv
//**********************************************************
// Testbench for the memory subsystem. Directed tests on
// the request port against a behavioural SRAM.
//**********************************************************

`timescale 1ns/10ps

module tb_dut;

    import procyon_system_pkg::*;

    // about the number of requests issued over all tests.
    localparam int NUM_OPS = 64;
    localparam int WORDS = 1 << (SRAM_ADDR_WIDTH - 1);
    localparam wb_addr_t WINDOW_BYTES = 32'h0008_0000;

    logic       clk = 1'b0;
    logic       i_rst;
    logic       i_req;
    logic       i_req_we;
    wb_sel_t    i_req_sel;
    wb_addr_t   i_req_addr;
    wb_data_t   i_req_wdata;
    logic       o_busy;
    logic       o_done;
    wb_data_t   o_rd_data;
    sram_addr_t o_sram_addr;
    sram_data_t i_sram_dq;
    sram_data_t o_sram_dq;
    logic       o_sram_ce_n;
    logic       o_sram_oe_n;
    logic       o_sram_we_n;
    logic       o_sram_ub_n;
    logic       o_sram_lb_n;
    wb_data_t   ref_mem [0:WORDS-1];
    logic [31:0] rng_state = 32'h29df_44e5;
    int         ce_cycles = 0;

    always #4 clk = ~clk;

    dut DUT (.*);

    tb_sram_model sram_model (
        .i_clk(clk),
        .i_addr(o_sram_addr),
        .i_dq(o_sram_dq),
        .o_dq(i_sram_dq),
        .i_ce_n(o_sram_ce_n),
        .i_oe_n(o_sram_oe_n),
        .i_we_n(o_sram_we_n),
        .i_ub_n(o_sram_ub_n),
        .i_lb_n(o_sram_lb_n)
    );

    always @(posedge clk) begin
        if (!o_sram_ce_n) begin
            ce_cycles <= ce_cycles + 1;
        end
    end

    initial begin
        repeat (NUM_OPS * 20 + 5) @(posedge clk);
        $display("Test failed");
        $fatal(1, "watchdog timeout, a request never completed");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sram_data_t fill_value(input logic [17:0] a);
        return {a[7:0], a[15:8]} ^ {14'h0, a[17:16]};
    endfunction

    function automatic logic in_window(input wb_addr_t addr);
        return (addr - SRAM_BASE_ADDR) < WINDOW_BYTES;
    endfunction

    function automatic int word_index(input wb_addr_t addr);
        return int'((addr - SRAM_BASE_ADDR) >> 2);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // one request on the port, returning once o_done has been seen.
    task automatic run_request(input logic we, input wb_sel_t sel, input wb_addr_t addr,
                               input wb_data_t wdata);
        @(posedge clk);
        i_req       <= 1'b1;
        i_req_we    <= we;
        i_req_sel   <= sel;
        i_req_addr  <= addr;
        i_req_wdata <= wdata;
        @(posedge clk);
        i_req <= 1'b0;
        @(posedge clk);
        check_value("o_busy", o_busy, 32'd1);
        while (!o_done) begin
            @(posedge clk);
        end
    endtask

    task automatic do_write(input wb_addr_t addr, input wb_sel_t sel, input wb_data_t data);
        run_request(1'b1, sel, addr, data);
        if (in_window(addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    ref_mem[word_index(addr)][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic do_read(input wb_addr_t addr, input wb_sel_t sel);
        wb_data_t expected;
        expected = '0;
        run_request(1'b0, sel, addr, '0);
        if (in_window(addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    expected[8*b +: 8] = ref_mem[word_index(addr)][8*b +: 8];
                end
            end
        end
        check_value("o_rd_data", o_rd_data, expected);
    endtask

    task automatic reset_state_check();
        @(posedge clk);
        check_value("sram control pins", {o_sram_ce_n, o_sram_oe_n, o_sram_we_n,
                    o_sram_ub_n, o_sram_lb_n}, 32'h1f);
        check_value("o_busy", o_busy, 32'd0);
        check_value("o_done", o_done, 32'd0);
    endtask

    task automatic full_word_access();
        wb_addr_t addrs [4] = '{32'h0000_0000, 32'h0000_0104, 32'h0004_2a10, 32'h0007_fffc};
        foreach (addrs[i]) begin
            rng_state = xorshift32(rng_state);
            do_write(addrs[i], 4'hf, rng_state);
        end
        foreach (addrs[i]) begin
            do_read(addrs[i], 4'hf);
        end
    endtask

    task automatic byte_lane_merge();
        do_write(32'h0000_0200, 4'hf, 32'ha5a5_5a5a);
        do_write(32'h0000_0200, 4'b0010, 32'h1122_3344);
        do_read(32'h0000_0200, 4'hf);
        do_write(32'h0000_0200, 4'b1001, 32'hdead_beef);
        do_read(32'h0000_0200, 4'hf);
        do_write(32'h0000_0200, 4'b0100, 32'h0f0f_0f0f);
        do_read(32'h0000_0200, 4'hf);
    endtask

    task automatic outside_window_access();
        int count_before;
        count_before = ce_cycles;
        // this address would alias word zero if the decode dropped the upper bits.
        do_write(32'h0008_0000, 4'hf, 32'hffff_0000);
        check_value("ce_n low cycles", ce_cycles, count_before);
        do_read(32'h0000_0000, 4'hf);
        count_before = ce_cycles;
        do_read(32'h8000_1230, 4'hf);
        check_value("ce_n low cycles", ce_cycles, count_before);
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        wb_addr_t    addr;
        for (int n = 0; n < 40; n++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            addr = {13'h0, r[31:29], 8'h00, r[5:0], 2'b00};
            rng_state = xorshift32(rng_state);
            if (r[8]) begin
                do_write(addr, r[12:9], rng_state);
            end else begin
                do_read(addr, r[12:9]);
            end
        end
    endtask

    task automatic skipped_halves();
        int count_before;
        do_write(32'h0000_0300, 4'hf, 32'h1357_9bdf);
        // only the upper half-word is accessed, one setup cycle plus the strobe.
        count_before = ce_cycles;
        do_read(32'h0000_0300, 4'b1100);
        check_value("ce_n low cycles", ce_cycles, count_before + 1 + SRAM_STROBE_CYCLES);
        count_before = ce_cycles;
        do_write(32'h0000_0300, 4'h0, 32'hffff_ffff);
        do_read(32'h0000_0300, 4'h0);
        check_value("ce_n low cycles", ce_cycles, count_before);
        do_read(32'h0000_0300, 4'hf);
    endtask

    initial begin
        i_rst       = 1'b1;
        i_req       = 1'b0;
        i_req_we    = 1'b0;
        i_req_sel   = '0;
        i_req_addr  = '0;
        i_req_wdata = '0;
        for (int w = 0; w < WORDS; w++) begin
            ref_mem[w] = {fill_value(18'(2 * w + 1)), fill_value(18'(2 * w))};
        end
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;
        reset_state_check();
        full_word_access();
        byte_lane_merge();
        outside_window_access();
        random_traffic();
        skipped_halves();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: tb_sram_model.sv
//**********************************************************
// Behavioural asynchronous SRAM, 16 bits wide with two
// byte lanes, for the memory subsystem testbench.
//**********************************************************

`timescale 1ns/10ps

module tb_sram_model (
    input  logic                           i_clk,
    input  procyon_system_pkg::sram_addr_t i_addr,
    input  procyon_system_pkg::sram_data_t i_dq,
    output procyon_system_pkg::sram_data_t o_dq,
    input  logic                           i_ce_n,
    input  logic                           i_oe_n,
    input  logic                           i_we_n,
    input  logic                           i_ub_n,
    input  logic                           i_lb_n
);

    import procyon_system_pkg::*;

    sram_data_t mem [0:(1 << SRAM_ADDR_WIDTH) - 1];

    // every cell starts with a value built from its whole address.
    initial begin
        for (int a = 0; a < (1 << SRAM_ADDR_WIDTH); a++) begin
            mem[a] = {a[7:0], a[15:8]} ^ {14'h0, a[17:16]};
        end
    end

    // enabled lanes take the data while ce_n and we_n are both low.
    always @(posedge i_clk) begin
        if (!i_ce_n && !i_we_n) begin
            if (!i_lb_n) begin
                mem[i_addr][7:0] <= i_dq[7:0];
            end
            if (!i_ub_n) begin
                mem[i_addr][15:8] <= i_dq[15:8];
            end
        end
    end

    // disabled lanes read back as zero.
    assign o_dq[7:0]  = (!i_ce_n && !i_oe_n && !i_lb_n) ? mem[i_addr][7:0] : 8'h00;
    assign o_dq[15:8] = (!i_ce_n && !i_oe_n && !i_ub_n) ? mem[i_addr][15:8] : 8'h00;

endmodule

// File: wb_cmd_master.sv
//**********************************************************
// Wishbone command master.
// Turns one request from the top level into one classic
// Wishbone cycle and hands back the result.
//**********************************************************

`timescale 1ns/10ps

module wb_cmd_master (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic                        i_req,
    input  logic                        i_req_we,
    input  procyon_system_pkg::wb_sel_t  i_req_sel,
    input  procyon_system_pkg::wb_addr_t i_req_addr,
    input  procyon_system_pkg::wb_data_t i_req_wdata,
    output logic                        o_busy,
    output logic                        o_done,
    output procyon_system_pkg::wb_data_t o_rd_data,
    wb_if.master                        wb
);

    import procyon_system_pkg::*;

    typedef enum logic {
        MST_IDLE     = 1'b0,
        MST_WAIT_ACK = 1'b1
    } mst_state_t;

    mst_state_t state;
    logic       cyc_q;
    logic       stb_q;
    logic       we_q;
    wb_sel_t    sel_q;
    wb_addr_t   addr_q;
    wb_data_t   wdata_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state  <= MST_IDLE;
            cyc_q  <= 1'b0;
            stb_q  <= 1'b0;
            o_busy <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;

            // busy stays up through the done cycle and drops right after it.
            if (o_done) begin
                o_busy <= 1'b0;
            end

            case (state)
                MST_IDLE: begin
                    if (i_req) begin
                        state  <= MST_WAIT_ACK;
                        cyc_q  <= 1'b1;
                        stb_q  <= 1'b1;
                        o_busy <= 1'b1;
                    end
                end
                MST_WAIT_ACK: begin
                    if (wb.ack) begin
                        state  <= MST_IDLE;
                        cyc_q  <= 1'b0;
                        stb_q  <= 1'b0;
                        o_done <= 1'b1;
                    end
                end
                default: state <= MST_IDLE;
            endcase
        end
    end

    // the request is held on the bus unchanged until the slave acks it.
    always_ff @(posedge clk) begin
        if (state == MST_IDLE && i_req) begin
            we_q    <= i_req_we;
            sel_q   <= i_req_sel;
            addr_q  <= i_req_addr;
            wdata_q <= i_req_wdata;
        end

        if (state == MST_WAIT_ACK && wb.ack && !we_q) begin
            o_rd_data <= wb.dat_s2m;
        end
    end

    assign wb.cyc     = cyc_q;
    assign wb.stb     = stb_q;
    assign wb.we      = we_q;
    assign wb.sel     = sel_q;
    assign wb.addr    = addr_q;
    assign wb.dat_m2s = wdata_q;

    assert property (@(posedge clk) disable iff (i_rst) i_req |-> !o_busy);
    assert property (@(posedge clk) disable iff (i_rst) wb.stb |-> wb.cyc);

endmodule

// File: wb_if.sv
//**********************************************************
// Wishbone classic bus between the command master and
// the SRAM slave.
//**********************************************************

`timescale 1ns/10ps

interface wb_if;

    import procyon_system_pkg::*;

    logic     cyc;
    logic     stb;
    logic     we;
    wb_sel_t  sel;
    wb_addr_t addr;
    wb_data_t dat_m2s;
    wb_data_t dat_s2m;
    logic     ack;

    modport master (
        output cyc, stb, we, sel, addr, dat_m2s,
        input  dat_s2m, ack
    );

    modport slave (
        input  cyc, stb, we, sel, addr, dat_m2s,
        output dat_s2m, ack
    );

endinterface
